//--- common/cpuPkg.sv
package cpuPkg;

    // Data path widths
    typedef logic [31:0] wordT;
    typedef logic [63:0] dWordT;
    typedef logic [8:0]  memAddrT;
    typedef logic [3:0]  regIdxT;

    // Opcode field, instruction bits 31 to 27
    typedef enum logic [4:0] {
        ld     = 5'd0,
        ldi    = 5'd1,
        st     = 5'd2,
        add    = 5'd3,
        sub    = 5'd4,
        andOp  = 5'd5,
        orOp   = 5'd6,
        mul    = 5'd7,
        mfhi   = 5'd8,
        mflo   = 5'd9,
        inOp   = 5'd10,
        outOp  = 5'd11,
        halt   = 5'd12
    } opcodeT;

    // T-states, numbered so that the next step is one more
    typedef enum logic [3:0] {
        T0       = 4'd0,
        T1       = 4'd1,
        T2       = 4'd2,
        T3       = 4'd3,
        T4       = 4'd4,
        T5       = 4'd5,
        T6       = 4'd6,
        T7       = 4'd7,
        stHalted = 4'd8
    } stepT;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluMul = 3'd4
    } aluOpT;

    // One control word per bus cycle
    typedef struct packed {
        // Bus sources, one at a time
        logic  pcOut;
        logic  mdrOut;
        logic  zHighOut;
        logic  zLowOut;
        logic  hiOut;
        logic  loOut;
        logic  cOut;
        logic  inPortOut;
        logic  rOut;
        // Register and memory enables
        logic  pcIn;
        logic  incPc;
        logic  marIn;
        logic  mdrIn;
        logic  read;
        logic  write;
        logic  irIn;
        logic  yIn;
        logic  zIn;
        logic  hiIn;
        logic  loIn;
        logic  outPortIn;
        logic  rIn;
        logic  baOut;
        // Which IR field names the register
        logic  gra;
        logic  grb;
        logic  grc;
        aluOpT aluOp;
    } ctrlT;

endpackage

//--- datapath/registerFile.sv
`timescale 1ns/10ps

module registerFile (
    input  logic         Clock,
    input  logic         rstN,
    input  cpuPkg::wordT ir,
    input  logic         gra,
    input  logic         grb,
    input  logic         grc,
    input  logic         rIn,
    input  logic         rOut,
    input  logic         baOut,
    input  cpuPkg::wordT busIn,
    output cpuPkg::wordT busOut
);
    import cpuPkg::*;

    wordT   regs [16];
    regIdxT sel;
    wordT   selValue;

    // ra, rb, rc fields of IR
    always_comb begin
        if (gra) begin
            sel = ir[26:23];
        end else if (grb) begin
            sel = ir[22:19];
        end else if (grc) begin
            sel = ir[18:15];
        end else begin
            sel = '0;
        end
    end

    // Base address mode: R0 counts as zero
    assign selValue = (baOut && sel == '0) ? '0 : regs[sel];
    assign busOut   = rOut ? selValue : '0;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (rIn) begin
            regs[sel] <= busIn;
        end
    end

endmodule

//--- datapath/alu.sv
`timescale 1ns/10ps

module alu (
    input  cpuPkg::aluOpT op,
    input  cpuPkg::wordT  a,
    input  cpuPkg::wordT  b,
    output cpuPkg::dWordT result
);
    import cpuPkg::*;

    logic signed [63:0] aExt;
    logic signed [63:0] bExt;
    logic signed [63:0] product;
    wordT               low;

    // Sign-extend both operands so the product is the full signed value
    assign aExt    = {{32{a[31]}}, a};
    assign bExt    = {{32{b[31]}}, b};
    assign product = aExt * bExt;

    always_comb begin
        case (op)
            aluAdd: begin
                low = a + b;
            end
            aluSub: begin
                low = a - b;
            end
            aluAnd: begin
                low = a & b;
            end
            aluOr: begin
                low = a | b;
            end
            default: begin
                low = '0;
            end
        endcase
    end

    // Only mul fills the high half
    always_comb begin
        if (op == aluMul) begin
            result = dWordT'(product);
        end else begin
            result = {32'd0, low};
        end
    end

endmodule

//--- datapath/datapath.sv
`timescale 1ns/10ps

module datapath (
    input  logic            Clock,
    input  logic            rstN,
    input  cpuPkg::ctrlT    ctrl,
    input  cpuPkg::wordT    readData,
    input  cpuPkg::wordT    inPort,
    output cpuPkg::wordT    ir,
    output cpuPkg::memAddrT marValue,
    output cpuPkg::wordT    mdrValue,
    output cpuPkg::wordT    outPort,
    output logic            outValid
);
    import cpuPkg::*;

    wordT    bus;
    wordT    regBus;
    wordT    cSext;
    wordT    pc;
    wordT    mdr;
    wordT    y;
    wordT    hi;
    wordT    lo;
    dWordT   z;
    dWordT   aluResult;
    memAddrT mar;

    // Constant C is bits 18 to 0, sign-extended
    assign cSext = {{13{ir[18]}}, ir[18:0]};

    // Single shared bus; sources are gated and ORed, only one is ever on
    always_comb begin
        bus = regBus;
        bus = bus | ({32{ctrl.pcOut}} & pc);
        bus = bus | ({32{ctrl.mdrOut}} & mdr);
        bus = bus | ({32{ctrl.zHighOut}} & z[63:32]);
        bus = bus | ({32{ctrl.zLowOut}} & z[31:0]);
        bus = bus | ({32{ctrl.hiOut}} & hi);
        bus = bus | ({32{ctrl.loOut}} & lo);
        bus = bus | ({32{ctrl.cOut}} & cSext);
        bus = bus | ({32{ctrl.inPortOut}} & inPort);
    end

    // Control state
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            pc       <= '0;
            ir       <= '0;
            outValid <= 1'b0;
        end else begin
            if (ctrl.incPc) begin
                pc <= pc + 32'd1;
            end else if (ctrl.pcIn) begin
                pc <= bus;
            end
            if (ctrl.irIn) begin
                ir <= bus;
            end
            // Valid follows the cycle that loads the port
            outValid <= ctrl.outPortIn;
        end
    end

    // Payload registers
    always_ff @(posedge Clock) begin
        if (ctrl.marIn) begin
            mar <= bus[$bits(memAddrT)-1:0];
        end
        if (ctrl.mdrIn) begin
            mdr <= ctrl.read ? readData : bus;
        end
        if (ctrl.yIn) begin
            y <= bus;
        end
        if (ctrl.zIn) begin
            z <= aluResult;
        end
        if (ctrl.hiIn) begin
            hi <= bus;
        end
        if (ctrl.loIn) begin
            lo <= bus;
        end
        if (ctrl.outPortIn) begin
            outPort <= bus;
        end
    end

    assign marValue = mar;
    assign mdrValue = mdr;

    registerFile regs (
        .Clock  (Clock),
        .rstN   (rstN),
        .ir     (ir),
        .gra    (ctrl.gra),
        .grb    (ctrl.grb),
        .grc    (ctrl.grc),
        .rIn    (ctrl.rIn),
        .rOut   (ctrl.rOut),
        .baOut  (ctrl.baOut),
        .busIn  (bus),
        .busOut (regBus)
    );

    // Y is the first operand, the bus the second
    alu aluUnit (
        .op     (ctrl.aluOp),
        .a      (y),
        .b      (bus),
        .result (aluResult)
    );

endmodule

//--- control/controlUnit.sv
`timescale 1ns/10ps

module controlUnit (
    input  logic         Clock,
    input  logic         rstN,
    input  logic         run,
    input  cpuPkg::wordT ir,
    output cpuPkg::ctrlT ctrl,
    output logic         instrDone,
    output logic         halted
);
    import cpuPkg::*;

    stepT   step;
    stepT   stepNext;
    stepT   lastStep;
    opcodeT opcode;
    logic   active;

    assign opcode = opcodeT'(ir[31:27]);

    // A started instruction always runs to its end
    assign active = run || (step != T0);

    always_comb begin
        case (opcode)
            ld, st: begin
                lastStep = T7;
            end
            mul: begin
                lastStep = T6;
            end
            ldi, add, sub, andOp, orOp: begin
                lastStep = T5;
            end
            default: begin
                lastStep = T3;
            end
        endcase
    end

    assign instrDone = (step == lastStep);
    assign halted    = (step == stHalted);

    always_comb begin
        if (step == stHalted) begin
            stepNext = stHalted;
        end else if (!active) begin
            stepNext = T0;
        end else if (step == T3 && opcode == halt) begin
            stepNext = stHalted;
        end else if (step == lastStep) begin
            stepNext = T0;
        end else begin
            stepNext = stepT'(step + 4'd1);
        end
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            step <= T0;
        end else begin
            step <= stepNext;
        end
    end

    // Control word for the current step
    always_comb begin
        ctrl = '0;
        if (active && step != stHalted) begin
            case (step)
                T0: begin
                    ctrl.pcOut = 1'b1;
                    ctrl.marIn = 1'b1;
                    ctrl.incPc = 1'b1;
                end
                T1: begin
                    ctrl.read  = 1'b1;
                    ctrl.mdrIn = 1'b1;
                end
                T2: begin
                    ctrl.mdrOut = 1'b1;
                    ctrl.irIn   = 1'b1;
                end
                default: begin
                    case (opcode)
                        // Effective address C(rb) goes through Y and Z
                        ld, st, ldi: begin
                            if (step == T3) begin
                                ctrl.grb   = 1'b1;
                                ctrl.rOut  = 1'b1;
                                ctrl.baOut = 1'b1;
                                ctrl.yIn   = 1'b1;
                            end else if (step == T4) begin
                                ctrl.cOut = 1'b1;
                                ctrl.zIn  = 1'b1;
                            end else if (step == T5) begin
                                ctrl.zLowOut = 1'b1;
                                if (opcode == ldi) begin
                                    ctrl.gra = 1'b1;
                                    ctrl.rIn = 1'b1;
                                end else begin
                                    ctrl.marIn = 1'b1;
                                end
                            end else if (step == T6) begin
                                ctrl.mdrIn = 1'b1;
                                // st puts ra into MDR
                                if (opcode == ld) begin
                                    ctrl.read = 1'b1;
                                end else begin
                                    ctrl.gra  = 1'b1;
                                    ctrl.rOut = 1'b1;
                                end
                            end else if (step == T7) begin
                                if (opcode == ld) begin
                                    ctrl.mdrOut = 1'b1;
                                    ctrl.gra    = 1'b1;
                                    ctrl.rIn    = 1'b1;
                                end else begin
                                    ctrl.write = 1'b1;
                                end
                            end
                        end
                        // ra = rb op rc
                        add, sub, andOp, orOp: begin
                            if (step == T3) begin
                                ctrl.grb  = 1'b1;
                                ctrl.rOut = 1'b1;
                                ctrl.yIn  = 1'b1;
                            end else if (step == T4) begin
                                ctrl.grc  = 1'b1;
                                ctrl.rOut = 1'b1;
                                ctrl.zIn  = 1'b1;
                                case (opcode)
                                    sub:     ctrl.aluOp = aluSub;
                                    andOp:   ctrl.aluOp = aluAnd;
                                    orOp:    ctrl.aluOp = aluOr;
                                    default: ctrl.aluOp = aluAdd;
                                endcase
                            end else if (step == T5) begin
                                ctrl.zLowOut = 1'b1;
                                ctrl.gra     = 1'b1;
                                ctrl.rIn     = 1'b1;
                            end
                        end
                        // HI:LO = ra * rb
                        mul: begin
                            if (step == T3) begin
                                ctrl.gra  = 1'b1;
                                ctrl.rOut = 1'b1;
                                ctrl.yIn  = 1'b1;
                            end else if (step == T4) begin
                                ctrl.grb   = 1'b1;
                                ctrl.rOut  = 1'b1;
                                ctrl.zIn   = 1'b1;
                                ctrl.aluOp = aluMul;
                            end else if (step == T5) begin
                                ctrl.zLowOut = 1'b1;
                                ctrl.loIn    = 1'b1;
                            end else if (step == T6) begin
                                ctrl.zHighOut = 1'b1;
                                ctrl.hiIn     = 1'b1;
                            end
                        end
                        mfhi: begin
                            ctrl.hiOut = 1'b1;
                            ctrl.gra   = 1'b1;
                            ctrl.rIn   = 1'b1;
                        end
                        mflo: begin
                            ctrl.loOut = 1'b1;
                            ctrl.gra   = 1'b1;
                            ctrl.rIn   = 1'b1;
                        end
                        inOp: begin
                            ctrl.inPortOut = 1'b1;
                            ctrl.gra       = 1'b1;
                            ctrl.rIn       = 1'b1;
                        end
                        outOp: begin
                            ctrl.gra       = 1'b1;
                            ctrl.rOut      = 1'b1;
                            ctrl.outPortIn = 1'b1;
                        end
                        // halt and unused opcodes move nothing
                        default: begin
                        end
                    endcase
                end
            endcase
        end
    end

endmodule

//--- source/memory.sv
`timescale 1ns/10ps

module memory #(
    parameter int memWords = 512
) (
    input  logic            Clock,
    input  cpuPkg::memAddrT addr,
    input  cpuPkg::wordT    writeData,
    input  logic            write,
    input  logic            loadEn,
    input  cpuPkg::memAddrT loadAddr,
    input  cpuPkg::wordT    loadData,
    output cpuPkg::wordT    readData
);
    import cpuPkg::*;

    wordT ram [memWords];

    // Loads come only while the core is stopped
    always_ff @(posedge Clock) begin
        if (write) begin
            ram[addr] <= writeData;
        end else if (loadEn) begin
            ram[loadAddr] <= loadData;
        end
    end

    // Asynchronous read at the MAR address
    assign readData = ram[addr];

endmodule

//--- source/cpuCore.sv
`timescale 1ns/10ps

module cpuCore #(
    parameter int memWords = 512
) (
    input  logic            Clock,
    input  logic            rstN,
    input  logic            run,
    input  logic            loadEn,
    input  cpuPkg::memAddrT loadAddr,
    input  cpuPkg::wordT    loadData,
    input  cpuPkg::wordT    inPort,
    output cpuPkg::wordT    outPort,
    output logic            outValid,
    output logic            instrDone,
    output logic            halted
);
    import cpuPkg::*;

    ctrlT    ctrl;
    wordT    ir;
    wordT    mdrValue;
    wordT    readData;
    memAddrT marValue;

    controlUnit control (
        .Clock     (Clock),
        .rstN      (rstN),
        .run       (run),
        .ir        (ir),
        .ctrl      (ctrl),
        .instrDone (instrDone),
        .halted    (halted)
    );

    datapath dp (
        .Clock    (Clock),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .readData (readData),
        .inPort   (inPort),
        .ir       (ir),
        .marValue (marValue),
        .mdrValue (mdrValue),
        .outPort  (outPort),
        .outValid (outValid)
    );

    memory #(
        .memWords (memWords)
    ) ram (
        .Clock     (Clock),
        .addr      (marValue),
        .writeData (mdrValue),
        .write     (ctrl.write),
        .loadEn    (loadEn),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .readData  (readData)
    );

endmodule

//--- tests/cpuCore_assertions.sv
`timescale 1ns/10ps

module cpuCore_assertions (
    input logic         Clock,
    input logic         rstN,
    input logic         run,
    input cpuPkg::ctrlT ctrl,
    input logic         outValid,
    input logic         instrDone,
    input logic         halted
);

    logic started;

    // Set once the core has been told to run
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            started <= 1'b0;
        end else if (run) begin
            started <= 1'b1;
        end
    end

    // Outputs come out of reset quiet
    resetQuiet: assert property (@(posedge Clock)
        !rstN |=> (!outValid && !instrDone && !halted))
        else $error("status outputs active in the cycle after reset");

    // Idle core before the first run drives no enables
    idleQuiet: assert property (@(posedge Clock) disable iff (!rstN)
        (!started && !run) |-> (ctrl == '0 && !outValid && !instrDone && !halted))
        else $error("core active before run was raised");

    outValidPulse: assert property (@(posedge Clock) disable iff (!rstN)
        outValid |=> !outValid)
        else $error("outValid high for more than one cycle");

    instrDonePulse: assert property (@(posedge Clock) disable iff (!rstN)
        instrDone |=> !instrDone)
        else $error("instrDone high for more than one cycle");

    haltedSticky: assert property (@(posedge Clock) disable iff (!rstN)
        halted |=> halted)
        else $error("halted dropped without reset");

    haltedSilent: assert property (@(posedge Clock) disable iff (!rstN)
        halted |-> !outValid)
        else $error("outValid raised while halted");

endmodule

bind cpuCore cpuCore_assertions protocolChecks (
    .Clock     (Clock),
    .rstN      (rstN),
    .run       (run),
    .ctrl      (ctrl),
    .outValid  (outValid),
    .instrDone (instrDone),
    .halted    (halted)
);

//--- tests/cpuCoreTb.sv
`timescale 1ns/10ps

module cpuCoreTb;
    import cpuPkg::*;

    localparam int outTimeout  = 200;
    localparam int haltTimeout = 100;
    localparam int quietCycles = 40;

    // Data words and the store target, as 19-bit constants for the program
    localparam logic [18:0] addrA   = 19'd256;
    localparam logic [18:0] addrB   = 19'd257;
    localparam logic [18:0] addrC   = 19'd258;
    localparam logic [18:0] addrD   = 19'd259;
    localparam logic [18:0] addrE   = 19'd260;
    localparam logic [18:0] addrF   = 19'd261;
    localparam logic [18:0] addrSum = 19'd300;

    logic    Clock = 1'b0;
    logic    rstN;
    logic    run;
    logic    loadEn;
    memAddrT loadAddr;
    wordT    loadData;
    wordT    inPort;
    wordT    outPort;
    logic    outValid;
    logic    instrDone;
    logic    halted;

    logic [31:0] rngState = 32'd82;
    wordT        programWords[$];
    string       testNames[$];
    wordT        expectedValues[$];
    int          testCount = 0;
    int          failedTests = 0;
    int          errorCount = 0;
    int          doneCount = 0;
    logic        timedOut = 1'b0;

    cpuCore #(
        .memWords (512)
    ) u_dut (
        .Clock     (Clock),
        .rstN      (rstN),
        .run       (run),
        .loadEn    (loadEn),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .inPort    (inPort),
        .outPort   (outPort),
        .outValid  (outValid),
        .instrDone (instrDone),
        .halted    (halted)
    );

    always #10 Clock = ~Clock;

    // Each instruction ends with one instrDone pulse
    always @(negedge Clock) begin
        if (rstN === 1'b1 && instrDone === 1'b1) begin
            doneCount++;
        end
    end

    function automatic wordT nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // ld, ldi, st: ra, rb and a 19-bit constant
    function automatic wordT immInstr(input opcodeT op, input regIdxT ra, input regIdxT rb,
                                      input logic [18:0] c);
        return {op, ra, rb, c};
    endfunction

    function automatic wordT regInstr(input opcodeT op, input regIdxT ra, input regIdxT rb,
                                      input regIdxT rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic wordT signExtend19(input logic [18:0] c);
        return {{13{c[18]}}, c};
    endfunction

    task automatic writeWord(input memAddrT addr, input wordT data);
        @(posedge Clock);
        #1;
        loadEn   = 1'b1;
        loadAddr = addr;
        loadData = data;
    endtask

    task automatic expectLater(input string name, input wordT value);
        testNames.push_back(name);
        expectedValues.push_back(value);
    endtask

    // Waits for the next outValid and compares the port
    task automatic expectOutput(input string name, input wordT expected);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < outTimeout) begin
            @(negedge Clock);
            seen = outValid;
            cycles++;
        end
        testCount++;
        if (!seen) begin
            $display("Test %s: no outValid within %0d cycles", name, outTimeout);
            failedTests++;
            errorCount++;
            timedOut = 1'b1;
        end else begin
            assert (outPort === expected) else begin
                $display("Error at %0t ns: outPort = %h, expected %h", $time, outPort, expected);
                failedTests++;
                errorCount++;
            end
            $display("Test %s: %s", name, (outPort === expected) ? "ok" : "mismatch");
        end
    endtask

    task automatic checkHalt();
        int cycles;
        int errorsBefore;
        cycles       = 0;
        errorsBefore = errorCount;
        while (!halted && cycles < haltTimeout) begin
            @(negedge Clock);
            cycles++;
        end
        testCount++;
        if (!halted) begin
            $display("Test halt: halted did not rise within %0d cycles", haltTimeout);
            failedTests++;
            errorCount++;
            timedOut = 1'b1;
        end else begin
            // A stopped core stays stopped and silent
            repeat (quietCycles) begin
                @(negedge Clock);
                assert (halted === 1'b1) else begin
                    $display("Error at %0t ns: halted = %b, expected 1", $time, halted);
                    errorCount++;
                end
                assert (outValid === 1'b0) else begin
                    $display("Error at %0t ns: outValid = %b, expected 0", $time, outValid);
                    errorCount++;
                end
            end
            if (errorCount == errorsBefore) begin
                $display("Test halt: ok");
            end else begin
                $display("Test halt: %0d errors", errorCount - errorsBefore);
                failedTests++;
            end
        end
    endtask

    // One pulse per executed instruction, halt included
    task automatic checkDoneCount(input int expected);
        testCount++;
        assert (doneCount == expected) else begin
            $display("Error at %0t ns: instrDone pulses = %0d, expected %0d",
                     $time, doneCount, expected);
            failedTests++;
            errorCount++;
        end
        $display("Test instrDone count: %s", (doneCount == expected) ? "ok" : "mismatch");
    endtask

    initial begin
        wordT              a;
        wordT              b;
        wordT              c;
        wordT              d;
        wordT              e;
        wordT              f;
        wordT              inValue;
        logic [18:0]       k1;
        logic [18:0]       k2;
        logic signed [63:0] eWide;
        logic signed [63:0] fWide;
        logic signed [63:0] product;

        rstN     = 1'b0;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        a        = nextRandom();
        b        = nextRandom();
        c        = nextRandom();
        d        = nextRandom();
        e        = nextRandom();
        f        = nextRandom();
        inValue  = nextRandom();
        k1       = 19'(nextRandom());
        k2       = 19'(nextRandom());
        inPort   = inValue;

        repeat (10) @(posedge Clock);
        #1;
        rstN = 1'b1;

        programWords.push_back(immInstr(ld, 4'd1, 4'd0, addrA));
        programWords.push_back(immInstr(ld, 4'd2, 4'd0, addrB));
        programWords.push_back(regInstr(add, 4'd3, 4'd1, 4'd2));
        programWords.push_back(immInstr(st, 4'd3, 4'd0, addrSum));
        programWords.push_back(immInstr(ld, 4'd4, 4'd0, addrSum));
        programWords.push_back(regInstr(outOp, 4'd4, 4'd0, 4'd0));
        programWords.push_back(immInstr(ld, 4'd5, 4'd0, addrC));
        programWords.push_back(immInstr(ld, 4'd6, 4'd0, addrD));
        programWords.push_back(regInstr(sub, 4'd7, 4'd5, 4'd6));
        programWords.push_back(regInstr(outOp, 4'd7, 4'd0, 4'd0));
        programWords.push_back(regInstr(andOp, 4'd8, 4'd5, 4'd6));
        programWords.push_back(regInstr(outOp, 4'd8, 4'd0, 4'd0));
        programWords.push_back(regInstr(orOp, 4'd9, 4'd5, 4'd6));
        programWords.push_back(regInstr(outOp, 4'd9, 4'd0, 4'd0));
        programWords.push_back(immInstr(ldi, 4'd10, 4'd0, k1));
        programWords.push_back(regInstr(outOp, 4'd10, 4'd0, 4'd0));
        // R5 as base adds the register to C
        programWords.push_back(immInstr(ldi, 4'd11, 4'd5, k2));
        programWords.push_back(regInstr(outOp, 4'd11, 4'd0, 4'd0));
        programWords.push_back(immInstr(ld, 4'd12, 4'd0, addrE));
        programWords.push_back(immInstr(ld, 4'd13, 4'd0, addrF));
        programWords.push_back(regInstr(mul, 4'd12, 4'd13, 4'd0));
        programWords.push_back(regInstr(mflo, 4'd14, 4'd0, 4'd0));
        programWords.push_back(regInstr(outOp, 4'd14, 4'd0, 4'd0));
        programWords.push_back(regInstr(mfhi, 4'd15, 4'd0, 4'd0));
        programWords.push_back(regInstr(outOp, 4'd15, 4'd0, 4'd0));
        programWords.push_back(regInstr(inOp, 4'd1, 4'd0, 4'd0));
        programWords.push_back(regInstr(outOp, 4'd1, 4'd0, 4'd0));
        programWords.push_back(regInstr(halt, 4'd0, 4'd0, 4'd0));

        for (int i = 0; i < programWords.size(); i++) begin
            writeWord(memAddrT'(i), programWords[i]);
        end
        writeWord(addrA[8:0], a);
        writeWord(addrB[8:0], b);
        writeWord(addrC[8:0], c);
        writeWord(addrD[8:0], d);
        writeWord(addrE[8:0], e);
        writeWord(addrF[8:0], f);
        @(posedge Clock);
        #1;
        loadEn = 1'b0;

        eWide   = $signed(e);
        fWide   = $signed(f);
        product = eWide * fWide;
        expectLater("load-store", a + b);
        expectLater("sub", c - d);
        expectLater("and", c & d);
        expectLater("or", c | d);
        expectLater("ldi base R0", signExtend19(k1));
        expectLater("ldi base R5", c + signExtend19(k2));
        expectLater("mul low", product[31:0]);
        expectLater("mul high", product[63:32]);
        expectLater("in port", inValue);

        @(posedge Clock);
        #1;
        run = 1'b1;

        foreach (testNames[i]) begin
            if (!timedOut) begin
                expectOutput(testNames[i], expectedValues[i]);
            end
        end
        if (!timedOut) begin
            checkHalt();
        end
        if (!timedOut) begin
            checkDoneCount(programWords.size());
        end

        $display("Tests: %0d run, %0d failed, %0d errors", testCount, failedTests, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
common/cpuPkg.sv
datapath/registerFile.sv
datapath/alu.sv
datapath/datapath.sv
control/controlUnit.sv
source/memory.sv
source/cpuCore.sv
tests/cpuCore_assertions.sv
tests/cpuCoreTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module cpuCoreTb -Mdir obj_dir

output=$(./obj_dir/VcpuCoreTb)
echo "$output"

echo "$output" | grep -qx "sim passed"
